// File: src/corr_pkg.sv
package corr_pkg;

   // ------------------------------------------------------------------
   // Array geometry
   // ------------------------------------------------------------------

   // Antenna pairs visited per pass
   localparam int N_SLOTS = 12;

   typedef logic [3:0]  slot_t;     // Slot index within a pass
   typedef logic [11:0] ant_t;      // One sample bit per antenna
   typedef logic [3:0]  ant_idx_t;  // Antenna number 0 to 11

   // Bus word address
   // Bit 4 picks sin (1) or cos (0), bits 3..0 give the slot
   typedef logic [4:0]  wb_adr_t;

   // ------------------------------------------------------------------
   // Composite types
   // ------------------------------------------------------------------

   // Antenna pair of one slot, b in the high nibble and a in the low one
   typedef struct packed {
      ant_idx_t b_idx;
      ant_idx_t a_idx;
   } pair_t;

   // Control word that travels with each sample through the pipeline
   typedef struct packed {
      logic  valid;   // Sample was accepted with en
      logic  clear;   // First visit after a bank toggle, so base is zero
      logic  bank;    // Accumulator bank in use
      slot_t slot;    // Pair slot
   } stage_t;

endpackage

// File: src/corr_sequencer.sv
`timescale 1ns/100ps

module corr_sequencer (
   input  logic             clk_x,
   input  logic             rst,
   input  logic             en,        // Sample valid, advances the slot
   input  logic             sw,        // Bank switch request
   output corr_pkg::stage_t rd_stage,  // Head of the pipeline
   output logic             bank       // Bank being accumulated
);

   import corr_pkg::*;

   // ------------------------------------------------------------------
   // Slot and bank state
   // ------------------------------------------------------------------

   slot_t slot_q;
   logic  bank_q;
   logic  clear_q;    // Current pass starts every slot from zero
   logic  pend_q;     // Switch requested but wrap not reached yet
   logic  wrap;

   // Last slot accepted this cycle
   assign wrap = en && (slot_q == slot_t'(N_SLOTS - 1));

   // Slot counter holds on cycles without en
   always_ff @(posedge clk_x) begin
      if (rst) begin
         slot_q <= '0;
      end else if (en) begin
         if (wrap) begin
            slot_q <= '0;
         end else begin
            slot_q <= slot_q + slot_t'(1);
         end
      end
   end

   // ------------------------------------------------------------------
   // Deferred bank switch
   // ------------------------------------------------------------------

   // Slot 11 still goes to the old bank since rd_stage samples bank_q
   // before the toggle lands
   always_ff @(posedge clk_x) begin
      if (rst) begin
         bank_q  <= 1'b0;
         clear_q <= 1'b1;   // Memory content unknown after reset
         pend_q  <= 1'b0;
      end else if (wrap && (sw || pend_q)) begin
         bank_q  <= ~bank_q;   // Toggle at the wrap
         clear_q <= 1'b1;      // Next pass restarts the counters
         pend_q  <= 1'b0;
      end else begin
         if (sw) begin
            pend_q <= 1'b1;    // Remember until slot 11
         end
         if (wrap) begin
            clear_q <= 1'b0;   // One full pass of zero bases done
         end
      end
   end

   // ------------------------------------------------------------------
   // Stage word for the read cycle
   // ------------------------------------------------------------------

   always_comb begin
      rd_stage.valid = en;
      rd_stage.clear = clear_q;
      rd_stage.bank  = bank_q;
      rd_stage.slot  = slot_q;
   end

   assign bank = bank_q;   // Bus reader takes the other one

endmodule

// File: src/pair_select.sv
`timescale 1ns/100ps

module pair_select #(
   // Entry i is the pair of slot i
   parameter corr_pkg::pair_t [corr_pkg::N_SLOTS-1:0] PAIRS = '0
) (
   input  logic             clk_x,
   input  logic             rst,
   input  corr_pkg::stage_t rd_stage,
   input  corr_pkg::ant_t   re,          // Real sample bits
   input  corr_pkg::ant_t   im,          // Imaginary sample bits
   output corr_pkg::stage_t mac_stage,
   output logic             ar,          // re of antenna a
   output logic             br,          // re of antenna b
   output logic             bi           // im of antenna b
);

   import corr_pkg::*;

   pair_t    cur_pair;
   ant_idx_t a_idx;
   ant_idx_t b_idx;

   // Pair table lookup for the slot being read
   assign cur_pair = PAIRS[rd_stage.slot];
   assign a_idx    = cur_pair.a_idx;
   assign b_idx    = cur_pair.b_idx;

   // ------------------------------------------------------------------
   // Stage register, lines up with the RAM read
   // ------------------------------------------------------------------

   always_ff @(posedge clk_x) begin
      if (rst) begin
         mac_stage <= '0;          // No valid samples in flight
      end else begin
         mac_stage <= rd_stage;
      end
   end

   // Selected sample bits, payload only
   always_ff @(posedge clk_x) begin
      ar <= re[a_idx];
      br <= re[b_idx];
      bi <= im[b_idx];
   end

endmodule

// File: src/corr_mac.sv
`timescale 1ns/100ps

module corr_mac #(
   parameter int ACCUM = 32
) (
   input  logic             clk_x,
   input  logic             rst,
   input  corr_pkg::stage_t mac_stage,
   input  logic             ar,
   input  logic             br,
   input  logic             bi,
   input  logic [ACCUM-1:0] rd_cos,        // Previous cos count of the slot
   input  logic [ACCUM-1:0] rd_sin,        // Previous sin count of the slot
   output corr_pkg::stage_t wr_stage,
   output logic [ACCUM-1:0] wr_cos,
   output logic [ACCUM-1:0] wr_sin,
   output logic             overflow_cos,  // Sticky until reset
   output logic             overflow_sin   // Sticky until reset
);

   // ------------------------------------------------------------------
   // One-bit complex multiply
   // ------------------------------------------------------------------

   logic             inc_cos;    // re(a) agrees with re(b)
   logic             inc_sin;    // re(a) agrees with im(b)
   logic [ACCUM-1:0] base_cos;
   logic [ACCUM-1:0] base_sin;
   logic [ACCUM:0]   sum_cos;    // Extra bit catches the carry
   logic [ACCUM:0]   sum_sin;

   assign inc_cos = (ar == br);
   assign inc_sin = (ar == bi);

   // Zero base on the first visit after a bank toggle
   assign base_cos = mac_stage.clear ? '0 : rd_cos;
   assign base_sin = mac_stage.clear ? '0 : rd_sin;

   assign sum_cos = {1'b0, base_cos} + {{ACCUM{1'b0}}, inc_cos};
   assign sum_sin = {1'b0, base_sin} + {{ACCUM{1'b0}}, inc_sin};

   // ------------------------------------------------------------------
   // Result and flag registers
   // ------------------------------------------------------------------

   always_ff @(posedge clk_x) begin
      if (rst) begin
         wr_stage     <= '0;
         overflow_cos <= 1'b0;
         overflow_sin <= 1'b0;
      end else begin
         wr_stage <= mac_stage;
         if (mac_stage.valid && sum_cos[ACCUM]) begin
            overflow_cos <= 1'b1;   // Count wrapped
         end
         if (mac_stage.valid && sum_sin[ACCUM]) begin
            overflow_sin <= 1'b1;
         end
      end
   end

   // Accumulators wrap modulo 2**ACCUM
   always_ff @(posedge clk_x) begin
      wr_cos <= sum_cos[ACCUM-1:0];
      wr_sin <= sum_sin[ACCUM-1:0];
   end

endmodule

// File: src/accum_ram.sv
`timescale 1ns/100ps

module accum_ram #(
   parameter int ACCUM = 32
) (
   input  logic             clk_x,
   input  corr_pkg::stage_t rd_stage,   // MAC read address
   input  corr_pkg::stage_t wr_stage,   // MAC write address and enable
   input  logic [ACCUM-1:0] wr_cos,
   input  logic [ACCUM-1:0] wr_sin,
   input  logic             bus_bank,   // Inactive bank
   input  corr_pkg::slot_t  bus_slot,
   output logic [ACCUM-1:0] rd_cos,     // Registered
   output logic [ACCUM-1:0] rd_sin,     // Registered
   output logic [ACCUM-1:0] bus_cos,    // Asynchronous
   output logic [ACCUM-1:0] bus_sin     // Asynchronous
);

   // ------------------------------------------------------------------
   // Storage, word address is {bank, slot}
   // ------------------------------------------------------------------

   logic [ACCUM-1:0] cos_mem [0:31];
   logic [ACCUM-1:0] sin_mem [0:31];

   // MAC operand read, ready one cycle later with the selected bits
   always_ff @(posedge clk_x) begin
      if (rd_stage.valid) begin
         rd_cos <= cos_mem[{rd_stage.bank, rd_stage.slot}];
         rd_sin <= sin_mem[{rd_stage.bank, rd_stage.slot}];
      end
   end

   // Write back of the MAC result
   always_ff @(posedge clk_x) begin
      if (wr_stage.valid) begin
         cos_mem[{wr_stage.bank, wr_stage.slot}] <= wr_cos;
         sin_mem[{wr_stage.bank, wr_stage.slot}] <= wr_sin;
      end
   end

   // Bus side, never the bank under accumulation after the switch settles
   assign bus_cos = cos_mem[{bus_bank, bus_slot}];
   assign bus_sin = sin_mem[{bus_bank, bus_slot}];

endmodule

// File: src/wb_reader.sv
`timescale 1ns/100ps

module wb_reader #(
   parameter int ACCUM = 32
) (
   input  logic              clk_x,
   input  logic              rst,
   input  logic              cyc,
   input  logic              stb,
   input  logic              we,        // Writes get ack only
   input  corr_pkg::wb_adr_t adr,
   input  logic [ACCUM-1:0]  dat_in,    // Not stored, the RAM is read only here
   input  logic              bank,      // Bank under accumulation
   input  logic [ACCUM-1:0]  bus_cos,
   input  logic [ACCUM-1:0]  bus_sin,
   output logic              ack,
   output logic [ACCUM-1:0]  dat_out,
   output logic              bus_bank,
   output corr_pkg::slot_t   bus_slot
);

   logic req;   // New request this cycle

   // Ack low in the cycle after a request, so a held stb repeats
   // every second cycle
   assign req = cyc && stb && !ack;

   // Always the bank that is not being written
   assign bus_bank = ~bank;
   assign bus_slot = adr[3:0];

   always_ff @(posedge clk_x) begin
      if (rst) begin
         ack <= 1'b0;
      end else begin
         ack <= req;   // One cycle pulse
      end
   end

   // Read data, bit 4 picks sin over cos
   always_ff @(posedge clk_x) begin
      if (req && !we) begin
         dat_out <= adr[4] ? bus_sin : bus_cos;
      end
   end

endmodule

// File: src/correlator_top.sv
`timescale 1ns/100ps

module correlator_top #(
   parameter int              ACCUM = 32,
   parameter corr_pkg::pair_t PAIR0 = 8'h60,   // b in high nibble, a in low
   parameter corr_pkg::pair_t PAIR1 = 8'h70,
   parameter corr_pkg::pair_t PAIR2 = 8'h80,
   parameter corr_pkg::pair_t PAIR3 = 8'h90,
   parameter corr_pkg::pair_t PAIR4 = 8'ha0,
   parameter corr_pkg::pair_t PAIR5 = 8'hb0,
   parameter corr_pkg::pair_t PAIR6 = 8'h61,
   parameter corr_pkg::pair_t PAIR7 = 8'h71,
   parameter corr_pkg::pair_t PAIR8 = 8'h81,
   parameter corr_pkg::pair_t PAIR9 = 8'h91,
   parameter corr_pkg::pair_t PAIRA = 8'ha1,
   parameter corr_pkg::pair_t PAIRB = 8'hb1
) (
   input  logic              clk_x,
   input  logic              rst,
   // Wishbone-style read port
   input  logic              cyc,
   input  logic              stb,
   input  logic              we,
   input  corr_pkg::wb_adr_t adr,
   input  logic [ACCUM-1:0]  dat_in,
   output logic              ack,
   output logic [ACCUM-1:0]  dat_out,
   // Antenna side
   input  logic              sw,            // Switch banks at next wrap
   input  logic              en,            // Samples valid
   input  corr_pkg::ant_t    re,
   input  corr_pkg::ant_t    im,
   output logic              overflow_cos,
   output logic              overflow_sin
);

   import corr_pkg::*;

   // Slot i of the table is PAIRi
   localparam pair_t [N_SLOTS-1:0] PAIRS = {PAIRB, PAIRA, PAIR9, PAIR8,
                                            PAIR7, PAIR6, PAIR5, PAIR4,
                                            PAIR3, PAIR2, PAIR1, PAIR0};

   // ------------------------------------------------------------------
   // Interconnect
   // ------------------------------------------------------------------

   stage_t           rd_stage;    // Read cycle
   stage_t           mac_stage;   // MAC cycle
   stage_t           wr_stage;    // Write cycle
   logic             bank;
   logic             ar;
   logic             br;
   logic             bi;
   logic [ACCUM-1:0] rd_cos;
   logic [ACCUM-1:0] rd_sin;
   logic [ACCUM-1:0] wr_cos;
   logic [ACCUM-1:0] wr_sin;
   logic [ACCUM-1:0] bus_cos;
   logic [ACCUM-1:0] bus_sin;
   logic             bus_bank;
   slot_t            bus_slot;

   corr_sequencer corr_sequencer_i (
      .clk_x, .rst, .en, .sw, .rd_stage, .bank
   );

   pair_select #(.PAIRS(PAIRS)) pair_select_i (
      .clk_x, .rst, .rd_stage, .re, .im, .mac_stage, .ar, .br, .bi
   );

   corr_mac #(.ACCUM(ACCUM)) corr_mac_i (
      .clk_x, .rst, .mac_stage, .ar, .br, .bi, .rd_cos, .rd_sin,
      .wr_stage, .wr_cos, .wr_sin, .overflow_cos, .overflow_sin
   );

   accum_ram #(.ACCUM(ACCUM)) accum_ram_i (
      .clk_x, .rd_stage, .wr_stage, .wr_cos, .wr_sin, .bus_bank, .bus_slot,
      .rd_cos, .rd_sin, .bus_cos, .bus_sin
   );

   wb_reader #(.ACCUM(ACCUM)) wb_reader_i (
      .clk_x, .rst, .cyc, .stb, .we, .adr, .dat_in, .bank, .bus_cos, .bus_sin,
      .ack, .dat_out, .bus_bank, .bus_slot
   );

endmodule

// File: bench/tb_correlator.sv
`timescale 1ns/100ps

module tb_correlator;

   import corr_pkg::*;

   localparam int ACC    = 8;   // Short counters so overflow is reachable
   localparam int N_ROWS = 6;

   // Pair of slot i, b in the high nibble and a in the low one
   localparam logic [7:0] PAIR_TAB [12] = '{8'h30, 8'h41, 8'h52, 8'h63, 8'h74, 8'h85,
                                            8'h96, 8'ha7, 8'hb8, 8'h09, 8'h1a, 8'h2b};

   // ------------------------------------------------------------------
   // Stimulus table, one column per array
   // ------------------------------------------------------------------
   localparam int PASSES  [N_ROWS] = '{3, 2, 3, 1, 260, 1};
   localparam int GAP     [N_ROWS] = '{1, 2, 1, 1, 1, 1};      // Cycles per sample
   localparam int SW_SLOT [N_ROWS] = '{11, 4, -1, 7, 11, 11};  // -1 is no switch
   localparam bit RDBK    [N_ROWS] = '{1, 1, 0, 1, 1, 1};      // Read inactive bank
   localparam bit ALL_ONE [N_ROWS] = '{0, 0, 0, 0, 1, 0};      // Constant agreeing bits

   logic           clk_x, rst;
   logic           cyc, stb, we, ack;
   wb_adr_t        adr;
   logic [ACC-1:0] dat_in, dat_out;
   logic           sw, en, overflow_cos, overflow_sin;
   ant_t           re, im;

   // Reference model of both banks
   int     m_cos [32];
   int     m_sin [32];
   int     m_slot;
   bit     m_bank, m_clear, m_pend, m_ovc, m_ovs;
   integer seed = 32'haccb1e57;
   int     cycles = 0;
   int     limit;

   correlator_top #(
      .ACCUM(ACC),
      .PAIR0(PAIR_TAB[0]), .PAIR1(PAIR_TAB[1]), .PAIR2(PAIR_TAB[2]), .PAIR3(PAIR_TAB[3]),
      .PAIR4(PAIR_TAB[4]), .PAIR5(PAIR_TAB[5]), .PAIR6(PAIR_TAB[6]), .PAIR7(PAIR_TAB[7]),
      .PAIR8(PAIR_TAB[8]), .PAIR9(PAIR_TAB[9]), .PAIRA(PAIR_TAB[10]), .PAIRB(PAIR_TAB[11])
   ) correlator_top_i (
      .clk_x, .rst, .cyc, .stb, .we, .adr, .dat_in, .ack, .dat_out,
      .sw, .en, .re, .im, .overflow_cos, .overflow_sin
   );

   always #20 clk_x = ~clk_x;   // 40 ns period

   task automatic fail_stop(input string msg);
      $display("%s", msg);
      $display("Verification failed");
      $fatal(1);
   endtask

   task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
      assert (got === exp) else fail_stop($sformatf("error: %s = 0x%h, expected 0x%h",
                                                    name, got, exp));
   endtask

   // Run guard
   always @(posedge clk_x) begin
      cycles = cycles + 1;
      if (cycles > limit) fail_stop("timeout, the run did not finish within the cycle limit");
   end

   // ------------------------------------------------------------------
   // Model, called once per accepted sample
   // ------------------------------------------------------------------
   task automatic model_accept(input ant_t r, input ant_t i, input logic s);
      int a, b, idx, c, n;
      a   = PAIR_TAB[m_slot][3:0];
      b   = PAIR_TAB[m_slot][7:4];
      idx = m_bank * 16 + m_slot;
      c   = (m_clear ? 0 : m_cos[idx]) + (r[a] == r[b]);   // Real parts agree
      n   = (m_clear ? 0 : m_sin[idx]) + (r[a] == i[b]);   // Re of a vs im of b
      if (c >= 2**ACC) m_ovc = 1'b1;
      if (n >= 2**ACC) m_ovs = 1'b1;
      m_cos[idx] = c % (2**ACC);
      m_sin[idx] = n % (2**ACC);
      if (m_slot == N_SLOTS - 1) begin
         if (s || m_pend) begin   // Toggle only at the wrap
            m_bank  = ~m_bank;
            m_clear = 1'b1;
            m_pend  = 1'b0;
         end else begin
            m_clear = 1'b0;
         end
         m_slot = 0;
      end else begin
         if (s) m_pend = 1'b1;    // Deferred switch
         m_slot++;
      end
   endtask

   // One table row, entered and left 2 ns after an edge
   task automatic run_row(input int r);
      int p, s, g;
      for (p = 0; p < PASSES[r]; p++) begin
         for (s = 0; s < N_SLOTS; s++) begin
            re = ALL_ONE[r] ? '1 : ant_t'($random(seed));
            im = ALL_ONE[r] ? '1 : ant_t'($random(seed));
            sw = (p == PASSES[r] - 1) && (s == SW_SLOT[r]);   // Last pass only
            en = 1'b1;
            model_accept(re, im, sw);
            for (g = 0; g < GAP[r]; g++) begin
               @(posedge clk_x);
               #2;
               sw = 1'b0;
               en = 1'b0;
               re = ant_t'($random(seed));   // Noise on idle cycles
               im = ant_t'($random(seed));
            end
         end
      end
   endtask

   // ------------------------------------------------------------------
   // Bus transfers, stb held so each ack comes every second cycle
   // ------------------------------------------------------------------
   task automatic write_word(input wb_adr_t a, input int d);
      check_val("ack", ack, 0);
      cyc    = 1'b1;
      stb    = 1'b1;
      we     = 1'b1;
      adr    = a;
      dat_in = d[ACC-1:0];
      @(posedge clk_x);
      #2;
      check_val("ack", ack, 1);   // Write is acknowledged
      @(posedge clk_x);
      #2;
   endtask

   task automatic read_word(input wb_adr_t a, input int exp);
      check_val("ack", ack, 0);   // Previous strobe got one ack only
      cyc = 1'b1;
      stb = 1'b1;
      we  = 1'b0;
      adr = a;
      @(posedge clk_x);
      #2;
      check_val("ack", ack, 1);
      check_val("dat_out", dat_out, exp);
      @(posedge clk_x);
      #2;
   endtask

   task automatic read_back();
      int sel, s, idx;
      repeat (4) begin   // Last old-bank write has landed by now
         @(posedge clk_x);
         #2;
      end
      // Slot 0 cos written with a different value, must be dropped
      write_word(5'h00, (m_cos[int'(!m_bank) * 16] + 1) % (2**ACC));
      for (sel = 0; sel < 2; sel++) begin
         for (s = 0; s < N_SLOTS; s++) begin
            idx = int'(!m_bank) * 16 + s;
            read_word(wb_adr_t'({sel[0], s[3:0]}), sel ? m_sin[idx] : m_cos[idx]);
         end
      end
      cyc = 1'b0;
      stb = 1'b0;
      @(posedge clk_x);
      #2;
      check_val("ack", ack, 0);
      check_val("overflow_cos", overflow_cos, m_ovc);   // Sticky flags
      check_val("overflow_sin", overflow_sin, m_ovs);
   endtask

   initial begin
      int r;
      clk_x   = 1'b0;
      rst     = 1'b1;
      cyc     = 1'b0;
      stb     = 1'b0;
      we      = 1'b0;
      adr     = '0;
      dat_in  = '0;
      sw      = 1'b0;
      en      = 1'b0;
      re      = '0;
      im      = '0;
      m_slot  = 0;
      m_bank  = 1'b0;
      m_clear = 1'b1;   // First pass after reset starts from zero
      m_pend  = 1'b0;
      m_ovc   = 1'b0;
      m_ovs   = 1'b0;
      limit   = 0;
      for (r = 0; r < N_ROWS; r++) begin
         limit += 2 * PASSES[r] * N_SLOTS * GAP[r] + (RDBK[r] ? 60 : 0);
      end
      repeat (5) @(posedge clk_x);
      #2;
      rst = 1'b0;
      check_val("ack", ack, 0);
      check_val("overflow_cos", overflow_cos, 0);
      for (r = 0; r < N_ROWS; r++) begin
         run_row(r);
         if (RDBK[r]) read_back();
      end
      $display("Verification passed");
      $finish;
   end

endmodule

// File: sim.f
src/corr_pkg.sv
src/corr_sequencer.sv
src/pair_select.sv
src/corr_mac.sv
src/accum_ram.sv
src/wb_reader.sv
src/correlator_top.sv
bench/tb_correlator.sv

// File: Bender.yml
package:
  name: correlator

sources:
  - src/corr_pkg.sv
  - src/corr_sequencer.sv
  - src/pair_select.sv
  - src/corr_mac.sv
  - src/accum_ram.sv
  - src/wb_reader.sv
  - src/correlator_top.sv
  - target: test
    files:
      - bench/tb_correlator.sv
